// File: Bender.yml
package:
  name: wisc_core

sources:
  - src/wiscPkg.sv
  - src/control.sv
  - src/immExtend.sv
  - src/regFile.sv
  - src/alu.sv
  - src/dataMem.sv
  - src/wiscCore.sv
  - target: test
    files:
      - tb/wiscCoreTb.sv

// File: src.f
src/wiscPkg.sv
src/control.sv
src/immExtend.sv
src/regFile.sv
src/alu.sv
src/dataMem.sv
src/wiscCore.sv
tb/wiscCoreTb.sv

// File: src/alu.sv
// ALU for arithmetic, logic, shifts, rotates, compares, bit reversal and byte loads
module alu import wiscPkg::*; (
    input  logic [DataWidth-1:0] opA,        // Rs
    input  logic [DataWidth-1:0] opB,        // Rt or immediate
    input  logic [4:0]           aluCntrl,
    output logic [DataWidth-1:0] result,
    output logic                 zero
);

    logic [DataWidth:0]     sum;             // A + B with carry out
    logic [DataWidth-1:0]   diff;            // Reverse subtract
    logic [3:0]             shAmt;
    logic [2*DataWidth-1:0] rotL;
    logic [2*DataWidth-1:0] rotR;

    assign sum   = {1'b0, opA} + {1'b0, opB};
    assign diff  = opB - opA;
    assign shAmt = opB[3:0];
    assign rotL  = {opA, opA} << shAmt;     // Upper half is the left rotate
    assign rotR  = {opA, opA} >> shAmt;     // Lower half is the right rotate
    assign zero  = (opA == '0);             // Branch test on Rs

    always_comb begin
        case (aluCntrl)
            opAddi:  result = sum[DataWidth-1:0];
            opSubi:  result = diff;
            opXori:  result = opA ^ opB;
            opAndni: result = opA & ~opB;
            opRoli:  result = rotL[2*DataWidth-1:DataWidth];
            opSlli:  result = opA << shAmt;
            opRori:  result = rotR[DataWidth-1:0];
            opSrli:  result = opA >> shAmt;
            opSeq:   result = DataWidth'(opA == opB);
            opSlt:   result = DataWidth'($signed(opA) < $signed(opB));
            opSle:   result = DataWidth'($signed(opA) <= $signed(opB));
            opSco:   result = DataWidth'(sum[DataWidth]);
            opBtr:   result = {<<{opA}};     // Bit reversal
            opLbi:   result = opB;
            opSlbi:  result = (opA << 8) | opB;
            default: result = '0;           // HALT, NOP and branches
        endcase
    end

endmodule

// File: src/control.sv
// Opcode decoder driving every datapath select and enable
module control import wiscPkg::*; (
    input  logic [4:0] opcode,
    output logic       regWrite,       // Register file write
    output destSel_t   destRegSel,     // Destination field select
    output logic       pcSel,          // PC + 2 + imm for J/JAL
    output logic       regJmp,         // PC from Rs + imm
    output logic       memEnable,      // Data memory access
    output logic       memWr,          // Data memory write
    output logic [4:0] aluCntrl,       // Operation code for the ALU
    output logic       val2Reg,        // Write back memory data
    output logic       aluSel,         // Operand B is the immediate
    output immSel_t    immSel,
    output logic       halt,
    output linkSel_t   linkReg,
    output logic       branch,         // Conditional zero-test branch
    output logic       illegalOp
);

    always_comb begin
        // Safe defaults, nothing written
        regWrite   = 1'b0;
        destRegSel = destRdI;
        pcSel      = 1'b0;
        regJmp     = 1'b0;
        memEnable  = 1'b0;
        memWr      = 1'b0;
        aluCntrl   = opcode;           // Pass opcode through
        val2Reg    = 1'b0;
        aluSel     = 1'b1;
        immSel     = immS5;
        halt       = 1'b0;
        linkReg    = linkNone;
        branch     = 1'b0;
        illegalOp  = 1'b0;

        casez (opcode)
            5'b000??: begin
                case (opcode)
                    opHalt: halt = 1'b1;
                    opNop, opSiic, opRti: halt = 1'b0;
                    default: illegalOp = 1'b1;
                endcase
            end
            5'b010??, 5'b101??: begin                   // I-format 1 arithmetic and shifts
                regWrite = 1'b1;
                immSel   = opcode[1] ? immZ5 : immS5;   // XORI/ANDNI/RORI/SRLI zero extend
            end
            5'b100??: begin
                if (opcode == opSlbi) begin
                    regWrite   = 1'b1;
                    destRegSel = destRs;
                    immSel     = immZ8;
                end else begin                          // ST, LD, STU address Rs + imm
                    aluCntrl   = opAddi;
                    memEnable  = 1'b1;
                    memWr      = (opcode != opLd);
                    regWrite   = (opcode != opSt);
                    val2Reg    = (opcode == opLd);
                    destRegSel = (opcode == opStu) ? destRs : destRdI;  // STU updates base
                end
            end
            5'b11000: begin                             // LBI
                regWrite   = 1'b1;
                destRegSel = destRs;
                immSel     = immS8;
                linkReg    = linkLbi;
            end
            5'b11001, 5'b1101?, 5'b111??: begin         // R-format group
                regWrite   = 1'b1;
                destRegSel = destRdR;
                aluSel     = 1'b0;                      // Operand B from Rt
                immSel     = immZ5;
            end
            5'b011??: begin                             // BEQZ/BNEZ/BLTZ/BGEZ
                branch = 1'b1;
                immSel = immS8;
            end
            5'b001??: begin                             // J, JR, JAL, JALR
                aluCntrl   = opAddi;                    // Rs + imm target for JR/JALR
                destRegSel = destR7;
                regJmp     = opcode[0];
                pcSel      = !opcode[0];
                immSel     = opcode[0] ? immS8 : immS11;
                if (opcode == opJal || opcode == opJalr) begin
                    regWrite = 1'b1;
                    linkReg  = linkPc;
                end
            end
            default: illegalOp = 1'b1;
        endcase
    end

endmodule

// File: src/dataMem.sv
// Word-addressed data memory, synchronous write and combinational read
module dataMem import wiscPkg::*; #(
    parameter int DmemWords = 256
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 enable,
    input  logic                 wr,
    input  logic [DataWidth-1:0] addr,       // Byte address
    input  logic [DataWidth-1:0] wrData,
    output logic [DataWidth-1:0] rdData
);

    localparam int AddrBits = $clog2(DmemWords);

    logic [DataWidth-1:0] mem [DmemWords];
    logic [AddrBits-1:0]  wordIdx;

    assign wordIdx = addr[AddrBits:1];       // Wraps modulo DmemWords

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < DmemWords; i++) begin
                mem[i] <= '0;
            end
        end else if (enable && wr) begin
            mem[wordIdx] <= wrData;
        end
    end

    assign rdData = mem[wordIdx];

endmodule

// File: src/immExtend.sv
// Immediate extractor with zero or sign extension of 5-, 8- and 11-bit fields
module immExtend import wiscPkg::*; (
    input  instrWord_t           instr,
    input  immSel_t              immSel,
    output logic [DataWidth-1:0] imm
);

    logic signExt;                     // Sign requested

    assign signExt = immSel[2];

    always_comb begin
        case (immSel[1:0])
            2'b00: begin
                imm = {{(DataWidth-5){signExt & instr.i1Fmt.imm[4]}}, instr.i1Fmt.imm};
            end
            2'b01: begin
                imm = {{(DataWidth-8){signExt & instr.i2Fmt.imm[7]}}, instr.i2Fmt.imm};
            end
            default: begin             // 11-bit jump displacement
                imm = {{(DataWidth-11){signExt & instr.jFmt.disp[10]}}, instr.jFmt.disp};
            end
        endcase
    end

endmodule

// File: src/regFile.sv
// Register file with eight words, two combinational reads and one write
module regFile import wiscPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [2:0]           rdAddrA,     // Rs field
    input  logic [2:0]           rdAddrB,     // Rt or I-format Rd field
    input  logic                 wrEn,
    input  logic [2:0]           wrAddr,
    input  logic [DataWidth-1:0] wrData,
    output logic [DataWidth-1:0] rdDataA,
    output logic [DataWidth-1:0] rdDataB
);

    logic [DataWidth-1:0] regs [8];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];    // Old value until the edge
    assign rdDataB = regs[rdAddrB];

endmodule

// File: src/wiscCore.sv
// Single-cycle core top: PC and halt registers, next-PC, writeback muxing, instances
module wiscCore import wiscPkg::*; #(
    parameter int DmemWords = 256
) (
    input  logic                 clk,
    input  logic                 rstN,
    output logic [DataWidth-1:0] pc,
    input  instrWord_t           instr,       // Answered in the same cycle
    output logic                 halted,
    output logic                 illegalOp,
    output logic                 wbEn,
    output logic [2:0]           wbReg,
    output logic [DataWidth-1:0] wbData,
    output logic                 memWrEn,
    output logic [DataWidth-1:0] memAddr,
    output logic [DataWidth-1:0] memWrData
);

    logic                 regWrite, pcSel, regJmp, memEnable, memWr;
    logic                 val2Reg, aluSel, halt, branch;
    destSel_t             destRegSel;
    immSel_t              immSel;
    linkSel_t             linkReg;
    logic [4:0]           aluCntrl;
    logic [4:0]           aluOp;          // R-format groups resolved by func
    logic [DataWidth-1:0] imm, rdDataA, rdDataB, opB;
    logic [DataWidth-1:0] aluResult, memRdData, pcInc, pcNext;
    logic                 aluZero, condMet;

    control control_i (
        .opcode(instr.rFmt.opcode), .regWrite, .destRegSel, .pcSel, .regJmp,
        .memEnable, .memWr, .aluCntrl, .val2Reg, .aluSel, .immSel, .halt,
        .linkReg, .branch, .illegalOp
    );

    immExtend immExtend_i (.instr, .immSel, .imm);

    regFile regFile_i (
        .clk, .rstN, .rdAddrA(instr.rFmt.rs), .rdAddrB(instr.rFmt.rt),
        .wrEn(wbEn), .wrAddr(wbReg), .wrData(wbData), .rdDataA, .rdDataB
    );

    // ADD..ANDN and ROL..SRL map onto the matching I-format ALU codes
    always_comb begin
        aluOp = aluCntrl;
        if (aluCntrl == opArithR) begin
            aluOp = {opAddi[4:2], instr.rFmt.func};
        end else if (aluCntrl == opShiftR) begin
            aluOp = {opRoli[4:2], instr.rFmt.func};
        end
    end

    assign opB = aluSel ? imm : rdDataB;

    alu alu_i (.opA(rdDataA), .opB, .aluCntrl(aluOp), .result(aluResult), .zero(aluZero));

    dataMem #(.DmemWords(DmemWords)) dataMem_i (
        .clk, .rstN, .enable(memEnable), .wr(memWrEn), .addr(aluResult),
        .wrData(rdDataB), .rdData(memRdData)
    );

    // Zero-test branch condition on Rs
    always_comb begin
        case (instr.i2Fmt.opcode)
            opBeqz:  condMet = aluZero;
            opBnez:  condMet = !aluZero;
            opBltz:  condMet = rdDataA[DataWidth-1];
            opBgez:  condMet = !rdDataA[DataWidth-1];
            default: condMet = 1'b0;
        endcase
    end

    assign pcInc  = pc + DataWidth'(2);
    assign pcNext = regJmp ? aluResult                        // JR/JALR target Rs + imm
                  : (pcSel || (branch && condMet)) ? pcInc + imm
                  : pcInc;

    always_comb begin
        case (destRegSel)
            destRs:  wbReg = instr.rFmt.rs;
            destRdR: wbReg = instr.rFmt.rd;
            destR7:  wbReg = 3'd7;
            default: wbReg = instr.i1Fmt.rd;
        endcase
    end

    assign wbData    = (linkReg == linkPc) ? pcInc : val2Reg ? memRdData : aluResult;
    assign wbEn      = regWrite && !halted;
    assign memWrEn   = memEnable && memWr && !halted;
    assign memAddr   = aluResult;
    assign memWrData = rdDataB;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            if (halt) begin
                halted <= 1'b1;                               // Sticky until reset
            end
            if (!halt && !halted) begin
                pc <= pcNext;                                 // PC stays on the HALT
            end
        end
    end

endmodule

// File: src/wiscPkg.sv
// Shared opcodes, control-field encodings and the instruction-word union
package wiscPkg;

    localparam int DataWidth = 16;                 // Machine word size

    // Special and control-flow opcodes
    localparam logic [4:0] opHalt  = 5'b00000;
    localparam logic [4:0] opNop   = 5'b00001;
    localparam logic [4:0] opSiic  = 5'b00010;     // No exception state, acts as NOP
    localparam logic [4:0] opRti   = 5'b00011;     // Likewise a NOP
    localparam logic [4:0] opJ     = 5'b00100;
    localparam logic [4:0] opJr    = 5'b00101;
    localparam logic [4:0] opJal   = 5'b00110;
    localparam logic [4:0] opJalr  = 5'b00111;
    localparam logic [4:0] opBeqz  = 5'b01100;
    localparam logic [4:0] opBnez  = 5'b01101;
    localparam logic [4:0] opBltz  = 5'b01110;
    localparam logic [4:0] opBgez  = 5'b01111;
    localparam logic [4:0] opSt    = 5'b10000;
    localparam logic [4:0] opLd    = 5'b10001;
    localparam logic [4:0] opSlbi  = 5'b10010;
    localparam logic [4:0] opStu   = 5'b10011;
    localparam logic [4:0] opLbi   = 5'b11000;

    // ALU opcodes, passed through by the decoder
    localparam logic [4:0] opAddi  = 5'b01000;
    localparam logic [4:0] opSubi  = 5'b01001;
    localparam logic [4:0] opXori  = 5'b01010;
    localparam logic [4:0] opAndni = 5'b01011;
    localparam logic [4:0] opRoli  = 5'b10100;
    localparam logic [4:0] opSlli  = 5'b10101;
    localparam logic [4:0] opRori  = 5'b10110;
    localparam logic [4:0] opSrli  = 5'b10111;
    localparam logic [4:0] opBtr   = 5'b11001;
    localparam logic [4:0] opShiftR = 5'b11010;    // ROL/SLL/ROR/SRL by func
    localparam logic [4:0] opArithR = 5'b11011;    // ADD/SUB/XOR/ANDN by func
    localparam logic [4:0] opSeq   = 5'b11100;
    localparam logic [4:0] opSlt   = 5'b11101;
    localparam logic [4:0] opSle   = 5'b11110;
    localparam logic [4:0] opSco   = 5'b11111;

    // R-format function codes, same order as the I-format low opcode bits
    localparam logic [1:0] fnAdd = 2'b00;
    localparam logic [1:0] fnSub = 2'b01;
    localparam logic [1:0] fnXor = 2'b10;
    localparam logic [1:0] fnAndn = 2'b11;
    localparam logic [1:0] fnRol = 2'b00;
    localparam logic [1:0] fnSll = 2'b01;
    localparam logic [1:0] fnRor = 2'b10;
    localparam logic [1:0] fnSrl = 2'b11;

    typedef logic [1:0] destSel_t;
    localparam destSel_t destRs  = 2'b00;
    localparam destSel_t destRdR = 2'b01;
    localparam destSel_t destR7  = 2'b10;
    localparam destSel_t destRdI = 2'b11;

    typedef logic [2:0] immSel_t;                  // {sign, size}, size 00:5 01:8 10:11
    localparam immSel_t immZ5  = 3'b000;
    localparam immSel_t immS5  = 3'b100;
    localparam immSel_t immZ8  = 3'b001;
    localparam immSel_t immS8  = 3'b101;
    localparam immSel_t immS11 = 3'b110;

    typedef logic [1:0] linkSel_t;
    localparam linkSel_t linkNone = 2'b00;
    localparam linkSel_t linkLbi  = 2'b01;
    localparam linkSel_t linkPc   = 2'b10;          // Write PC + 2 to R7

    typedef union packed {
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs, rt, rd;
            logic [1:0] func;
        } rFmt;
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs, rd;
            logic [4:0] imm;
        } i1Fmt;
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [7:0] imm;
        } i2Fmt;
        struct packed {
            logic [4:0]  opcode;
            logic [10:0] disp;
        } jFmt;
    } instrWord_t;

endpackage

// File: tb/wiscCoreTb.sv
// Single-cycle core testbench with program table, instruction port model, checks and report
module wiscCoreTb import wiscPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic                 clk, rstN;
    logic [DataWidth-1:0] pc;
    instrWord_t           instr;
    logic                 halted, illegalOp, wbEn, memWrEn;
    logic [2:0]           wbReg;
    logic [DataWidth-1:0] wbData, memAddr, memWrData;

    // Program table with one row per instruction word at index pc / 2
    logic [15:0] progWord [$];
    int          groupOf [$];
    bit          expWb [$];                   // Expected write-back enable
    logic [2:0]  expReg [$];
    logic [15:0] expData [$];
    bit          expSt [$];                   // Expected store enable
    logic [15:0] expAddr [$], expStData [$];
    int          nextIdx [$];                 // Index the PC moves to afterwards

    string groupTitle [1:5] = '{"immediate load and arithmetic", "R-format group", "memory",
                                "control flow", "halt and NOP forms"};
    int    checks, errors, groupErrors;

    wiscCore #(.DmemWords(64)) wiscCore_i (
        .clk, .rstN, .pc, .instr, .halted, .illegalOp, .wbEn, .wbReg, .wbData,
        .memWrEn, .memAddr, .memWrData
    );

    always #5 clk = ~clk;                     // 10 ns period

    // Instruction port model answering from the table on the falling edge
    always @(negedge clk) begin
        if (pc[15:1] < progWord.size()) begin
            instr <= progWord[pc[15:1]];
        end else begin
            instr <= {opNop, 11'd0};          // Off the end of the program
        end
    end

    function automatic logic [15:0] rWord(logic [4:0] op, logic [2:0] rs, rt, rd, logic [1:0] fn);
        return {op, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] i1Word(logic [4:0] op, logic [2:0] rs, rd, logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    function automatic logic [15:0] i2Word(logic [4:0] op, logic [2:0] rs, logic [7:0] imm);
        return {op, rs, imm};                 // Also J format with disp = {rs, imm}
    endfunction

    // Appends one row and then the slots that a taken jump passes over
    task automatic addRow(int grp, logic [15:0] word, bit wb, logic [2:0] wr, logic [15:0] wd,
                          bit st, logic [15:0] sa, logic [15:0] sd, int skip);
        progWord.push_back(word);
        groupOf.push_back(grp);
        expWb.push_back(wb);
        expReg.push_back(wr);
        expData.push_back(wd);
        expSt.push_back(st);
        expAddr.push_back(sa);
        expStData.push_back(sd);
        nextIdx.push_back(progWord.size() + skip);
        repeat (skip) begin
            addRow(grp, i2Word(opLbi, 0, 8'hEE), 1, 0, 16'hFFEE, 0, 0, 0, 0);  // Never runs
        end
    endtask

    task automatic checkVal(string name, logic [15:0] got, logic [15:0] want);
        checks++;
        assert (got === want) else begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, want);
            errors++;
            groupErrors++;
        end
    endtask

    task automatic checkRow(int i);
        checkVal("pc", pc, 16'(2 * i));
        checkVal("halted", halted, 1'b0);
        checkVal("illegalOp", illegalOp, 1'b0);      // All 32 opcodes are assigned
        checkVal("wbEn", wbEn, expWb[i]);
        if (expWb[i]) begin
            checkVal("wbReg", wbReg, expReg[i]);
            checkVal("wbData", wbData, expData[i]);
        end
        checkVal("memWrEn", memWrEn, expSt[i]);
        if (expSt[i]) begin
            checkVal("memAddr", memAddr, expAddr[i]);
            checkVal("memWrData", memWrData, expStData[i]);
        end
    endtask

    task automatic reportGroup(int g);
        $display("Test %0d (%s) finished with %0d errors", g, groupTitle[g], groupErrors);
        groupErrors = 0;
    endtask

    // Watchdog
    initial begin
        #1;                                   // Table is filled at time 0
        #((progWord.size() + 20) * 10);
        $display("Timeout: the core did not reach the end of the program in time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int idx;
        int haltIdx;
        int curGroup;
        bit done;
        clk       = 1'b0;
        rstN      = 1'b0;
        instr     = {opNop, 11'd0};
        checks    = 0;
        errors    = 0;
        groupErrors = 0;

        // grp, word, wbEn, wbReg, wbData, memWrEn, memAddr, memWrData, slots skipped
        addRow(1, i2Word(opLbi, 1, 8'h85), 1, 1, 16'hFF85, 0, 0, 0, 0);       // Sign extended
        addRow(1, i2Word(opSlbi, 1, 8'h3C), 1, 1, 16'h853C, 0, 0, 0, 0);
        addRow(1, i1Word(opAddi, 1, 2, 5'h1D), 1, 2, 16'h8539, 0, 0, 0, 0);   // Plus -3
        addRow(1, i1Word(opSubi, 1, 3, 5'd5), 1, 3, 16'h7AC9, 0, 0, 0, 0);    // 5 - r1
        addRow(1, i1Word(opXori, 1, 4, 5'h1F), 1, 4, 16'h8523, 0, 0, 0, 0);   // Zero extended
        addRow(1, i1Word(opAndni, 1, 5, 5'h1C), 1, 5, 16'h8520, 0, 0, 0, 0);
        addRow(2, i2Word(opLbi, 6, 8'h03), 1, 6, 16'h0003, 0, 0, 0, 0);
        addRow(2, rWord(opArithR, 1, 6, 2, fnAdd), 1, 2, 16'h853F, 0, 0, 0, 0);
        addRow(2, rWord(opArithR, 1, 6, 3, fnSub), 1, 3, 16'h7AC7, 0, 0, 0, 0);  // Rt - Rs
        addRow(2, rWord(opArithR, 1, 6, 4, fnXor), 1, 4, 16'h853F, 0, 0, 0, 0);
        addRow(2, rWord(opArithR, 1, 6, 5, fnAndn), 1, 5, 16'h853C, 0, 0, 0, 0);
        addRow(2, rWord(opShiftR, 1, 6, 2, fnSll), 1, 2, 16'h29E0, 0, 0, 0, 0);  // By 3
        addRow(2, rWord(opShiftR, 1, 6, 3, fnSrl), 1, 3, 16'h10A7, 0, 0, 0, 0);
        addRow(2, rWord(opShiftR, 1, 6, 4, fnRol), 1, 4, 16'h29E4, 0, 0, 0, 0);
        addRow(2, rWord(opShiftR, 1, 6, 5, fnRor), 1, 5, 16'h90A7, 0, 0, 0, 0);
        addRow(2, rWord(opSeq, 1, 1, 2, 2'b00), 1, 2, 16'h0001, 0, 0, 0, 0);   // Equal operands
        addRow(2, rWord(opSlt, 1, 6, 3, 2'b00), 1, 3, 16'h0001, 0, 0, 0, 0);   // Negative < 3
        addRow(2, rWord(opSle, 6, 1, 4, 2'b00), 1, 4, 16'h0000, 0, 0, 0, 0);
        addRow(2, rWord(opSco, 1, 1, 5, 2'b00), 1, 5, 16'h0001, 0, 0, 0, 0);   // Carry out
        addRow(2, rWord(opBtr, 1, 0, 2, 2'b00), 1, 2, 16'h3CA1, 0, 0, 0, 0);
        addRow(3, i1Word(opSt, 6, 1, 5'd5), 0, 0, 0, 1, 16'h0008, 16'h853C, 0);
        addRow(3, i1Word(opLd, 6, 2, 5'd5), 1, 2, 16'h853C, 0, 0, 0, 0);
        addRow(3, i1Word(opStu, 6, 5, 5'd7), 1, 6, 16'h000A, 1, 16'h000A, 16'h0001, 0);
        addRow(4, i2Word(opBeqz, 4, 8'd2), 0, 0, 0, 0, 0, 0, 1);              // r4 is 0
        addRow(4, i2Word(opBeqz, 3, 8'd2), 0, 0, 0, 0, 0, 0, 0);              // r3 is 1
        addRow(4, i2Word(opBnez, 3, 8'd2), 0, 0, 0, 0, 0, 0, 1);
        addRow(4, i2Word(opBnez, 4, 8'd2), 0, 0, 0, 0, 0, 0, 0);
        addRow(4, i2Word(opBltz, 1, 8'd2), 0, 0, 0, 0, 0, 0, 1);              // r1 negative
        addRow(4, i2Word(opBltz, 3, 8'd2), 0, 0, 0, 0, 0, 0, 0);
        addRow(4, i2Word(opBgez, 3, 8'd2), 0, 0, 0, 0, 0, 0, 1);
        addRow(4, i2Word(opBgez, 1, 8'd2), 0, 0, 0, 0, 0, 0, 0);
        addRow(4, i2Word(opJ, 0, 8'd2), 0, 0, 0, 0, 0, 0, 1);
        addRow(4, i2Word(opJal, 0, 8'd2), 1, 7, 16'h004C, 0, 0, 0, 1);        // Link PC 74 + 2
        addRow(4, i2Word(opJr, 6, 8'h48), 0, 0, 0, 0, 0, 0, 1);               // 10 + 72
        addRow(4, i2Word(opJalr, 6, 8'h4C), 1, 7, 16'h0054, 0, 0, 0, 1);      // 10 + 76
        addRow(5, i2Word(opSiic, 0, 8'd0), 0, 0, 0, 0, 0, 0, 0);
        addRow(5, i2Word(opRti, 0, 8'd0), 0, 0, 0, 0, 0, 0, 0);
        addRow(5, i2Word(opHalt, 0, 8'd0), 0, 0, 0, 0, 0, 0, 0);

        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        idx      = 0;
        curGroup = groupOf[0];
        done     = 1'b0;
        while (!done) begin
            #2;                               // Let the decode settle
            if (groupOf[idx] != curGroup) begin
                reportGroup(curGroup);
                curGroup = groupOf[idx];
            end
            checkRow(idx);
            done    = (progWord[idx][15:11] == opHalt);
            haltIdx = idx;
            idx     = nextIdx[idx];
            @(negedge clk);
        end

        repeat (5) begin                      // Core frozen on the HALT
            #2;
            checkVal("halted", halted, 1'b1);
            checkVal("pc", pc, 16'(2 * haltIdx));
            checkVal("wbEn", wbEn, 1'b0);
            checkVal("memWrEn", memWrEn, 1'b0);
            @(negedge clk);
        end
        reportGroup(curGroup);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
